/* isa_pkg.sv */
package isa_pkg;

    // RV32 base formats, one struct per encoding
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_slt  = 4'h2,
        alu_sltu = 4'h3,
        alu_and  = 4'h4,
        alu_or   = 4'h5,
        alu_xor  = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9
    } alu_func_e;

    typedef enum logic [1:0] {
        mult_mul    = 2'd0,  // Low word
        mult_mulh   = 2'd1,  // High word, signed x signed
        mult_mulhsu = 2'd2,  // High word, signed x unsigned
        mult_mulhu  = 2'd3
    } mult_func_e;

    typedef enum logic [1:0] {
        opa_is_rs1  = 2'd0,
        opa_is_pc   = 2'd1,
        opa_is_zero = 2'd2
    } opa_select_e;

    typedef enum logic [2:0] {
        opb_is_rs2   = 3'd0,
        opb_is_i_imm = 3'd1,
        opb_is_s_imm = 3'd2,
        opb_is_b_imm = 3'd3,
        opb_is_u_imm = 3'd4,
        opb_is_j_imm = 3'd5
    } opb_select_e;

    function automatic logic [31:0] signext_i_imm(inst_t inst);
        return {{20{inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic logic [31:0] signext_s_imm(inst_t inst);
        return {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
    endfunction

    // Branch offsets are in half words, bit 0 always zero
    function automatic logic [31:0] signext_b_imm(inst_t inst);
        return {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                inst.b.imm4_1, 1'b0};
    endfunction

    function automatic logic [31:0] signext_u_imm(inst_t inst);
        return {inst.u.imm, 12'b0};
    endfunction

    function automatic logic [31:0] signext_j_imm(inst_t inst);
        return {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
                inst.j.imm10_1, 1'b0};
    endfunction

endpackage

/* fu_pkg.sv */
package fu_pkg;

    typedef logic [31:0] data_t;    // Also pc and addresses
    typedef logic [5:0]  prn_t;
    typedef logic [4:0]  robn_t;

    // One issued operation from a reservation station
    typedef struct packed {
        logic                 valid;
        isa_pkg::inst_t       inst;
        data_t                pc;
        isa_pkg::alu_func_e   alu_func;
        isa_pkg::mult_func_e  mult_func;
        data_t                op1;
        data_t                op2;
        prn_t                 dest_prn;
        robn_t                robn;
        isa_pkg::opa_select_e opa_select;
        isa_pkg::opb_select_e opb_select;
        logic                 cond_branch;
        logic                 uncond_branch;
    } fu_packet_t;

    // Unit output toward the arbiter
    typedef struct packed {
        logic  valid;
        prn_t  dest_prn;
        robn_t robn;
        data_t value;
        logic  branch_taken;
    } fu_result_t;

    typedef struct packed {
        logic  valid;
        prn_t  dest_prn;
        data_t value;
    } cdb_packet_t;

    typedef struct packed {
        robn_t robn;
        logic  executed;
        logic  branch_taken;
        data_t target_addr;    // Zero unless taken
    } fu_rob_packet_t;

    typedef enum logic [1:0] {
        mult_idle = 2'd0,
        mult_busy = 2'd1,
        mult_done = 2'd2
    } mult_state_e;

endpackage

/* alu_cond.sv */
`timescale 1ns/100ps

module alu_cond (
    input  fu_pkg::fu_packet_t alu_packet,
    output fu_pkg::fu_result_t result
);
    import isa_pkg::*;
    import fu_pkg::*;

    data_t opa_mux;
    data_t opb_mux;
    data_t alu_out;
    logic  cond_true;
    logic  take_branch;

    always_comb begin
        case (alu_packet.opa_select)
            opa_is_rs1:  opa_mux = alu_packet.op1;
            opa_is_pc:   opa_mux = alu_packet.pc;
            opa_is_zero: opa_mux = '0;
            default:     opa_mux = 32'hdeadface;
        endcase
    end

    always_comb begin
        case (alu_packet.opb_select)
            opb_is_rs2:   opb_mux = alu_packet.op2;
            opb_is_i_imm: opb_mux = signext_i_imm(alu_packet.inst);
            opb_is_s_imm: opb_mux = signext_s_imm(alu_packet.inst);
            opb_is_b_imm: opb_mux = signext_b_imm(alu_packet.inst);
            opb_is_u_imm: opb_mux = signext_u_imm(alu_packet.inst);
            opb_is_j_imm: opb_mux = signext_j_imm(alu_packet.inst);
            default:      opb_mux = 32'hfacefeed;
        endcase
    end

    // Jump and branch targets come out of the adder as well
    always_comb begin
        case (alu_packet.alu_func)
            alu_add:  alu_out = opa_mux + opb_mux;
            alu_sub:  alu_out = opa_mux - opb_mux;
            alu_slt:  alu_out = {31'b0, $signed(opa_mux) < $signed(opb_mux)};
            alu_sltu: alu_out = {31'b0, opa_mux < opb_mux};
            alu_and:  alu_out = opa_mux & opb_mux;
            alu_or:   alu_out = opa_mux | opb_mux;
            alu_xor:  alu_out = opa_mux ^ opb_mux;
            alu_sll:  alu_out = opa_mux << opb_mux[4:0];
            alu_srl:  alu_out = opa_mux >> opb_mux[4:0];
            alu_sra:  alu_out = $signed(opa_mux) >>> opb_mux[4:0];
            default:  alu_out = 32'hfacebeec;
        endcase
    end

    // Condition on the raw register operands, not the muxed ones
    always_comb begin
        case (alu_packet.inst.b.funct3)
            3'b000:  cond_true = alu_packet.op1 == alu_packet.op2;
            3'b001:  cond_true = alu_packet.op1 != alu_packet.op2;
            3'b100:  cond_true = $signed(alu_packet.op1) < $signed(alu_packet.op2);
            3'b101:  cond_true = $signed(alu_packet.op1) >= $signed(alu_packet.op2);
            3'b110:  cond_true = alu_packet.op1 < alu_packet.op2;   // Unsigned
            3'b111:  cond_true = alu_packet.op1 >= alu_packet.op2;
            default: cond_true = 1'b0;
        endcase
    end

    assign take_branch = alu_packet.uncond_branch || (alu_packet.cond_branch && cond_true);

    always_comb begin
        result.valid        = alu_packet.valid;
        result.dest_prn     = alu_packet.dest_prn;
        result.robn         = alu_packet.robn;
        result.value        = alu_out;
        result.branch_taken = take_branch;
    end

endmodule

/* mult_ctrl.sv */
`timescale 1ns/100ps

module mult_ctrl (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                start,
    input  logic                last_step,
    input  logic                grant,
    output fu_pkg::mult_state_e state,
    output logic                avail
);
    import fu_pkg::*;

    mult_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            mult_idle: if (start) next_state = mult_busy;
            mult_busy: if (last_step) next_state = mult_done;
            mult_done: if (grant) next_state = mult_idle;   // Wait here for the CDB
            default:   next_state = mult_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= mult_idle;
        end else begin
            state <= next_state;
        end
    end

    // New multiply only accepted from idle
    assign avail = (state == mult_idle);

endmodule

/* mult_step_counter.sv */
`timescale 1ns/100ps

module mult_step_counter #(
    parameter int MULT_BITS_PER_STEP = 4
) (
    input  logic                clock,
    input  logic                rst_n,
    input  fu_pkg::mult_state_e state,
    output logic                last_step
);
    import fu_pkg::*;

    localparam int num_steps = 32 / MULT_BITS_PER_STEP;
    localparam int cnt_w     = $clog2(num_steps);

    logic [cnt_w-1:0] step_cnt;   // Steps already done

    always_ff @(posedge clock) begin
        if (!rst_n || state == mult_idle) begin
            step_cnt <= '0;
        end else if (state == mult_busy) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // High during the Nth busy cycle
    assign last_step = (state == mult_busy) && (step_cnt == cnt_w'(num_steps - 1));

endmodule

/* mult_datapath.sv */
`timescale 1ns/100ps

module mult_datapath #(
    parameter int MULT_BITS_PER_STEP = 4
) (
    input  logic                clock,
    input  logic                rst_n,
    input  fu_pkg::fu_packet_t  mult_packet,
    input  fu_pkg::mult_state_e state,
    output fu_pkg::fu_result_t  result
);
    import isa_pkg::*;
    import fu_pkg::*;

    logic        capture;
    logic        op1_neg;
    logic        op2_neg;
    data_t       op1_mag;
    data_t       op2_mag;
    logic [63:0] mcand;      // Shifted left every step
    data_t       mplier;     // Shifted right every step
    logic [63:0] partial;
    logic [63:0] acc;
    logic [63:0] product;
    logic        neg;
    mult_func_e  func;
    prn_t        dest_prn;
    robn_t       robn;

    assign capture = (state == mult_idle) && mult_packet.valid;

    // Signedness of each operand follows the opcode
    always_comb begin
        op1_neg = 1'b0;
        op2_neg = 1'b0;
        case (mult_packet.mult_func)
            mult_mulh: begin
                op1_neg = mult_packet.op1[31];
                op2_neg = mult_packet.op2[31];
            end
            mult_mulhsu: op1_neg = mult_packet.op1[31];
            default:     op1_neg = 1'b0;   // mul low word is sign blind
        endcase
        op1_mag = op1_neg ? -mult_packet.op1 : mult_packet.op1;
        op2_mag = op2_neg ? -mult_packet.op2 : mult_packet.op2;
    end

    assign partial = mcand * 64'(mplier[MULT_BITS_PER_STEP-1:0]);

    always_ff @(posedge clock) begin
        if (!rst_n || capture) begin
            acc <= '0;
        end else if (state == mult_busy) begin
            acc <= acc + partial;
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            mcand    <= {32'b0, op1_mag};
            mplier   <= op2_mag;
            neg      <= op1_neg ^ op2_neg;
            func     <= mult_packet.mult_func;
            dest_prn <= mult_packet.dest_prn;
            robn     <= mult_packet.robn;
        end else if (state == mult_busy) begin
            mcand  <= mcand << MULT_BITS_PER_STEP;
            mplier <= mplier >> MULT_BITS_PER_STEP;
        end
    end

    assign product = neg ? -acc : acc;   // Two's complement of the magnitude

    always_comb begin
        result.valid        = (state == mult_done);
        result.dest_prn     = dest_prn;
        result.robn         = robn;
        result.value        = (func == mult_mul) ? product[31:0] : product[63:32];
        result.branch_taken = 1'b0;
    end

endmodule

/* cdb_arbiter.sv */
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic                   clock,
    input  logic                   rst_n,
    input  fu_pkg::fu_result_t     alu_result,
    input  fu_pkg::fu_result_t     mult_result,
    output logic                   mult_grant,
    output fu_pkg::cdb_packet_t    cdb_packet,
    output fu_pkg::fu_rob_packet_t fu_rob_packet
);
    import fu_pkg::*;

    fu_result_t winner;
    fu_result_t out_q;
    logic       out_valid;

    // ALU never waits, the multiplier holds in done instead
    assign mult_grant = mult_result.valid && !alu_result.valid;
    assign winner     = alu_result.valid ? alu_result : mult_result;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= winner.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (winner.valid) begin
            out_q <= winner;
        end
    end

    always_comb begin
        cdb_packet.valid           = out_valid;
        cdb_packet.dest_prn        = out_q.dest_prn;
        cdb_packet.value           = out_q.value;
        fu_rob_packet.robn         = out_q.robn;
        fu_rob_packet.executed     = out_valid;
        fu_rob_packet.branch_taken = out_q.branch_taken;
        fu_rob_packet.target_addr  = out_q.branch_taken ? out_q.value : '0;
    end

endmodule

/* fu_bank.sv */
`timescale 1ns/100ps

module fu_bank #(
    parameter int MULT_BITS_PER_STEP = 4
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  fu_pkg::fu_packet_t     fu_alu_packet,
    input  fu_pkg::fu_packet_t     fu_mult_packet,
    output logic                   fu_alu_avail,
    output logic                   fu_mult_avail,
    output fu_pkg::cdb_packet_t    cdb_packet,
    output fu_pkg::fu_rob_packet_t fu_rob_packet
);
    import fu_pkg::*;

    fu_result_t  alu_result;
    fu_result_t  mult_result;
    mult_state_e mult_state;
    logic        mult_last_step;
    logic        mult_grant;

    assign fu_alu_avail = 1'b1;   // Single cycle, never busy

    alu_cond alu_cond0 (
        .alu_packet (fu_alu_packet),
        .result     (alu_result)
    );

    mult_ctrl mult_ctrl0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (fu_mult_packet.valid),   // Only looked at in idle
        .last_step (mult_last_step),
        .grant     (mult_grant),
        .state     (mult_state),
        .avail     (fu_mult_avail)
    );

    mult_step_counter #(
        .MULT_BITS_PER_STEP (MULT_BITS_PER_STEP)
    ) mult_step_counter0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .state     (mult_state),
        .last_step (mult_last_step)
    );

    mult_datapath #(
        .MULT_BITS_PER_STEP (MULT_BITS_PER_STEP)
    ) mult_datapath0 (
        .clock       (clock),
        .rst_n       (rst_n),
        .mult_packet (fu_mult_packet),
        .state       (mult_state),
        .result      (mult_result)
    );

    cdb_arbiter cdb_arbiter0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .alu_result    (alu_result),
        .mult_result   (mult_result),
        .mult_grant    (mult_grant),
        .cdb_packet    (cdb_packet),
        .fu_rob_packet (fu_rob_packet)
    );

endmodule

/* fu_bank_assert.sv */
`timescale 1ns/100ps

module fu_bank_assert (
    input logic                   clock,
    input logic                   rst_n,
    input fu_pkg::fu_packet_t     fu_mult_packet,
    input logic                   fu_mult_avail,
    input fu_pkg::cdb_packet_t    cdb_packet,
    input fu_pkg::fu_rob_packet_t fu_rob_packet
);

    // CDB broadcast and ROB notice always describe the same result
    cdb_rob_agree: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_packet.valid == fu_rob_packet.executed)
        else $error("CDB valid and ROB executed disagree");

    mult_accept_drops_avail: assert property (@(posedge clock) disable iff (!rst_n)
        fu_mult_avail && fu_mult_packet.valid |=> !fu_mult_avail)
        else $error("Multiplier still available the cycle after accepting a packet");

    cdb_valid_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown(cdb_packet.valid))
        else $error("CDB valid is unknown");

endmodule

bind fu_bank fu_bank_assert fu_bank_assert0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .fu_mult_packet (fu_mult_packet),
    .fu_mult_avail  (fu_mult_avail),
    .cdb_packet     (cdb_packet),
    .fu_rob_packet  (fu_rob_packet)
);

/* fu_bank_tb.sv */
`timescale 1ns/100ps

module fu_bank_tb;
    import isa_pkg::*;
    import fu_pkg::*;

    localparam int mult_steps     = 32 / 4;
    localparam int timeout_cycles = 3000;   // About three times the ~1000 cycles all tests take

    logic           clock;
    logic           rst_n;
    fu_packet_t     fu_alu_packet;
    fu_packet_t     fu_mult_packet;
    logic           fu_alu_avail;
    logic           fu_mult_avail;
    cdb_packet_t    cdb_packet;
    fu_rob_packet_t fu_rob_packet;
    int             errors = 0;
    int             checks = 0;
    int             cycle_cnt = 0;

    fu_bank #(.MULT_BITS_PER_STEP(4)) dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= timeout_cycles);
        $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Something failed");
        $finish;
    end

    // Inputs change and outputs are read 1 ns after the edge
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic report_mismatch(string what, data_t got, data_t exp);
        errors++;
        $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    function automatic data_t model_alu(fu_packet_t p);
        data_t a;
        data_t b;
        a = (p.opa_select == opa_is_pc) ? p.pc : (p.opa_select == opa_is_zero) ? '0 : p.op1;
        case (p.opb_select)
            opb_is_i_imm: b = signext_i_imm(p.inst);
            opb_is_s_imm: b = signext_s_imm(p.inst);
            opb_is_b_imm: b = signext_b_imm(p.inst);
            opb_is_u_imm: b = signext_u_imm(p.inst);
            opb_is_j_imm: b = signext_j_imm(p.inst);
            default:      b = p.op2;
        endcase
        case (p.alu_func)
            alu_sub:  return a - b;
            alu_slt:  return ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return a[31] ? ~(~a >> b[4:0]) : (a >> b[4:0]);   // Fill with sign
            default:  return a + b;
        endcase
    endfunction

    function automatic logic model_cond(logic [2:0] funct3, data_t a, data_t b);
        logic lt_s;
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (funct3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lt_s;
            3'b101:  return !lt_s;
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic data_t model_mult(mult_func_e f, data_t a, data_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = (f == mult_mulh || f == mult_mulhsu) ? {{32{a[31]}}, a} : {32'b0, a};
        eb = (f == mult_mulh) ? {{32{b[31]}}, b} : {32'b0, b};
        p  = ea * eb;   // Low 64 bits correct for any sign mix
        return (f == mult_mul) ? p[31:0] : p[63:32];
    endfunction

    function automatic fu_packet_t rand_packet();
        fu_packet_t p;
        p            = '0;
        p.valid      = 1'b1;
        p.inst       = $urandom;
        p.pc         = $urandom & 32'hffff_fffc;
        p.op1        = $urandom;
        p.op2        = $urandom;
        p.dest_prn   = prn_t'($urandom);
        p.robn       = robn_t'($urandom);
        p.alu_func   = alu_func_e'($urandom_range(9));
        p.opa_select = opa_select_e'($urandom_range(2));
        p.opb_select = opb_select_e'($urandom_range(5));
        return p;
    endfunction

    task automatic check_avail(logic exp);
        if (fu_mult_avail !== exp) report_mismatch("fu_mult_avail", 32'(fu_mult_avail), 32'(exp));
        if (fu_alu_avail !== 1'b1) report_mismatch("fu_alu_avail", 32'(fu_alu_avail), 1);
    endtask

    task automatic check_quiet(logic mult_avail);
        checks++;
        if (cdb_packet.valid !== 1'b0) report_mismatch("cdb valid", 32'(cdb_packet.valid), 0);
        if (fu_rob_packet.executed !== 1'b0)
            report_mismatch("rob executed", 32'(fu_rob_packet.executed), 0);
        check_avail(mult_avail);
    endtask

    task automatic check_out(prn_t prn, robn_t robn, data_t value, logic taken);
        checks++;
        if (cdb_packet.valid !== 1'b1) report_mismatch("cdb valid", 32'(cdb_packet.valid), 1);
        if (cdb_packet.dest_prn !== prn)
            report_mismatch("cdb dest_prn", 32'(cdb_packet.dest_prn), 32'(prn));
        if (cdb_packet.value !== value) report_mismatch("cdb value", cdb_packet.value, value);
        if (fu_rob_packet.robn !== robn)
            report_mismatch("rob robn", 32'(fu_rob_packet.robn), 32'(robn));
        if (fu_rob_packet.executed !== 1'b1)
            report_mismatch("rob executed", 32'(fu_rob_packet.executed), 1);
        if (fu_rob_packet.branch_taken !== taken)
            report_mismatch("rob branch_taken", 32'(fu_rob_packet.branch_taken), 32'(taken));
        if (fu_rob_packet.target_addr !== (taken ? value : 32'd0))
            report_mismatch("rob target_addr", fu_rob_packet.target_addr, taken ? value : 0);
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        step();
        step();
        rst_n = 1'b1;
        check_quiet(1'b1);
    endtask

    task automatic test_alu_ops();
        fu_packet_t p;
        for (int f = 0; f < 10; f++) begin
            for (int a = 0; a < 3; a++) begin
                for (int b = 0; b < 6; b++) begin
                    p            = rand_packet();
                    p.alu_func   = alu_func_e'(f);
                    p.opa_select = opa_select_e'(a);
                    p.opb_select = opb_select_e'(b);
                    fu_alu_packet = p;
                    step();
                    check_out(p.dest_prn, p.robn, model_alu(p), 1'b0);
                end
            end
        end
        fu_alu_packet = '0;
        step();
    endtask

    task automatic test_branches();
        fu_packet_t p;
        data_t      x;
        data_t      y;
        logic       taken;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int rel = 0; rel < 3; rel++) begin
                for (int kind = 0; kind < 2; kind++) begin
                    p = rand_packet();
                    x = $urandom;
                    y = (rel == 0) ? x : $urandom;
                    if ((rel == 1 && x > y) || (rel == 2 && x < y)) {x, y} = {y, x};
                    p.inst.b.funct3 = f3[2:0];
                    p.op1           = x;
                    p.op2           = y;
                    p.alu_func      = alu_add;
                    p.opa_select    = opa_is_pc;     // Target is pc plus offset
                    p.opb_select    = opb_is_b_imm;
                    p.cond_branch   = (kind == 0);
                    p.uncond_branch = (kind == 1);
                    taken = p.uncond_branch || (p.cond_branch && model_cond(f3[2:0], x, y));
                    fu_alu_packet = p;
                    step();
                    check_out(p.dest_prn, p.robn, p.pc + signext_b_imm(p.inst), taken);
                end
            end
        end
        fu_alu_packet = '0;
        step();
    endtask

    task automatic run_multiply(mult_func_e f, data_t x, data_t y);
        fu_packet_t p;
        p           = rand_packet();
        p.mult_func = f;
        p.op1       = x;
        p.op2       = y;
        while (fu_mult_avail !== 1'b1) step();
        fu_mult_packet = p;
        step();                      // Accept edge
        fu_mult_packet = '0;
        for (int c = 0; c <= mult_steps; c++) begin
            check_quiet(1'b0);
            step();
        end
        check_out(p.dest_prn, p.robn, model_mult(f, x, y), 1'b0);
        check_avail(1'b1);
    endtask

    task automatic test_multiply();
        data_t corner [3];
        data_t x;
        data_t y;
        corner = '{32'h8000_0000, 32'hffff_ffff, 32'h0};
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    x = (i < 3) ? corner[i] : $urandom;   // Index 3 picks a random word
                    y = (j < 3) ? corner[j] : $urandom;
                    run_multiply(mult_func_e'(f), x, y);
                end
            end
        end
    endtask

    task automatic test_back_pressure();
        fu_packet_t m;
        fu_packet_t p;
        m           = rand_packet();
        m.mult_func = mult_mulh;
        while (fu_mult_avail !== 1'b1) step();
        fu_mult_packet = m;
        step();
        fu_mult_packet = '0;
        // ALU stream runs well past the multiplier's done cycle
        for (int c = 0; c < mult_steps + 6; c++) begin
            p             = rand_packet();
            fu_alu_packet = p;
            step();
            check_out(p.dest_prn, p.robn, model_alu(p), 1'b0);
            check_avail(1'b0);
        end
        fu_alu_packet = '0;
        step();
        check_out(m.dest_prn, m.robn, model_mult(m.mult_func, m.op1, m.op2), 1'b0);
        check_avail(1'b1);
    endtask

    initial begin
        void'($urandom(32'ha1d59c70));
        rst_n          = 1'b0;
        fu_alu_packet  = '0;
        fu_mult_packet = '0;
        test_reset();
        test_alu_ops();
        test_branches();
        test_multiply();
        test_back_pressure();
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_cnt);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* ooo_fu.f */
isa_pkg.sv
fu_pkg.sv
alu_cond.sv
mult_ctrl.sv
mult_step_counter.sv
mult_datapath.sv
cdb_arbiter.sv
fu_bank.sv
fu_bank_assert.sv
fu_bank_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fu_bank_tb
FILELIST  = ooo_fu.f
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	else \
		echo "Result: PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
